/* rtl/execPkg.sv */
`default_nettype none

package execPkg;

    // Widths -----------------------------------------
    localparam int WordWidth    = 32;
    localparam int DwordWidth   = 64;
    localparam int HalfWidth    = 16;
    localparam int RegAddrWidth = 5;
    localparam int ShamtWidth   = 5;
    localparam int FuncWidth    = 6;

    typedef logic [WordWidth-1:0]    word_t;
    typedef logic [DwordWidth-1:0]   dword_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;
    typedef logic [ShamtWidth-1:0]   shamt_t;
    typedef logic [FuncWidth-1:0]    funcCode_t;

    // Function codes ---------------------------------
    localparam funcCode_t FuncSll   = 6'h00;
    localparam funcCode_t FuncSrl   = 6'h02;
    localparam funcCode_t FuncMovz  = 6'h0a;
    localparam funcCode_t FuncMovn  = 6'h0b;
    localparam funcCode_t FuncMfhi  = 6'h10;
    localparam funcCode_t FuncMflo  = 6'h12;
    localparam funcCode_t FuncMultu = 6'h19;
    // Not in SPECIAL, so free for the accumulate op
    localparam funcCode_t FuncMaddu = 6'h1d;
    localparam funcCode_t FuncAdd   = 6'h20;
    localparam funcCode_t FuncSub   = 6'h22;
    localparam funcCode_t FuncAnd   = 6'h24;
    localparam funcCode_t FuncOr    = 6'h25;
    localparam funcCode_t FuncXor   = 6'h26;
    localparam funcCode_t FuncSlt   = 6'h2a;
    localparam funcCode_t FuncClz   = 6'h3c;
    localparam funcCode_t FuncClo   = 6'h3d;

    // Stage records ----------------------------------
    typedef struct packed {
        funcCode_t Func;
        word_t     A;
        word_t     B;
        shamt_t    Shamt;
        regAddr_t  RAddr;
        logic      RegWrite;
    } execOp_t;

    typedef struct packed {
        logic Carry;
        logic Zero;
        logic Overflow;
        logic Negative;
    } aluFlags_t;

    typedef struct packed {
        logic      Valid;
        funcCode_t Func;
        regAddr_t  RAddr;
        logic      WriteEn;
        word_t     Data;
        aluFlags_t Flags;
    } aluStageOut_t;

    // Named by operand halves, A first
    typedef struct packed {
        word_t HiHi;
        word_t HiLo;
        word_t LoHi;
        word_t LoLo;
    } partials_t;

    typedef struct packed {
        regAddr_t  RAddr;
        logic      WriteEn;
        word_t     Data;
        aluFlags_t Flags;
    } execResult_t;

endpackage

`default_nettype wire

/* rtl/aluStage.sv */
`default_nettype none
`timescale 1ns/1ps

module aluStage (
    input  logic                  Clock,
    input  logic                  nReset,
    input  logic                  Hold,
    input  logic                  IssueValid,
    input  execPkg::execOp_t      IssueOp,
    output execPkg::aluStageOut_t AluOut
);
    import execPkg::*;

    logic [WordWidth:0] sum;
    logic [WordWidth:0] diff;
    word_t              aluData;
    aluFlags_t          flags;
    logic               writeEn;
    aluStageOut_t       next;

    function automatic word_t leadingZeros(input word_t value);
        word_t count;
        logic  found;
        count = '0;
        found = 1'b0;
        for (int i = WordWidth - 1; i >= 0; i--) begin
            if (value[i]) begin
                found = 1'b1;
            end else if (!found) begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

    assign sum  = {1'b0, IssueOp.A} + {1'b0, IssueOp.B};
    // Carry out here means no borrow
    assign diff = {1'b0, IssueOp.A} + {1'b0, ~IssueOp.B} + 1'b1;

    // Data and flags ---------------------------------
    always_comb begin
        aluData = '0;
        flags   = '0;
        case (IssueOp.Func)
            FuncAdd: begin
                aluData        = sum[WordWidth-1:0];
                flags.Carry    = sum[WordWidth];
                flags.Overflow = (IssueOp.A[WordWidth-1] == IssueOp.B[WordWidth-1])
                               && (sum[WordWidth-1] != IssueOp.A[WordWidth-1]);
            end
            FuncSub: begin
                aluData        = diff[WordWidth-1:0];
                flags.Carry    = diff[WordWidth];
                flags.Overflow = (IssueOp.A[WordWidth-1] != IssueOp.B[WordWidth-1])
                               && (diff[WordWidth-1] != IssueOp.A[WordWidth-1]);
            end
            FuncAnd:  aluData = IssueOp.A & IssueOp.B;
            FuncOr:   aluData = IssueOp.A | IssueOp.B;
            FuncXor:  aluData = IssueOp.A ^ IssueOp.B;
            FuncSlt:  aluData = word_t'($signed(IssueOp.A) < $signed(IssueOp.B));
            FuncSll:  aluData = IssueOp.B << IssueOp.Shamt;
            FuncSrl:  aluData = IssueOp.B >> IssueOp.Shamt;
            FuncClz:  aluData = leadingZeros(IssueOp.A);
            FuncClo:  aluData = leadingZeros(~IssueOp.A);
            FuncMovn, FuncMovz: aluData = IssueOp.A;
            default:  aluData = '0;
        endcase
        flags.Zero     = (aluData == '0);
        flags.Negative = aluData[WordWidth-1];
    end

    // Write enable, conditional moves included
    always_comb begin
        case (IssueOp.Func)
            FuncMovn:             writeEn = IssueOp.RegWrite && (IssueOp.B != '0);
            FuncMovz:             writeEn = IssueOp.RegWrite && (IssueOp.B == '0);
            FuncMultu, FuncMaddu: writeEn = 1'b0;
            default:              writeEn = IssueOp.RegWrite;
        endcase
    end

    assign next = '{
        Valid:   IssueValid,
        Func:    IssueOp.Func,
        RAddr:   IssueOp.RAddr,
        WriteEn: IssueValid && writeEn,
        Data:    aluData,
        Flags:   flags
    };

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            AluOut <= '0;
        end else if (!Hold) begin
            AluOut <= next;
        end
    end

    // Combiner decodes Func only on valid slots
    assert property (@(posedge Clock) disable iff (!nReset)
        AluOut.Valid |-> !$isunknown(AluOut.Func));

endmodule

`default_nettype wire

/* rtl/mulPartial.sv */
`default_nettype none
`timescale 1ns/1ps

module mulPartial (
    input  logic               Clock,
    input  logic               nReset,
    input  logic               Hold,
    input  execPkg::word_t     A,
    input  execPkg::word_t     B,
    output execPkg::partials_t Partials
);
    import execPkg::*;

    logic [HalfWidth-1:0] aHi;
    logic [HalfWidth-1:0] aLo;
    logic [HalfWidth-1:0] bHi;
    logic [HalfWidth-1:0] bLo;
    partials_t            next;

    assign aHi = A[WordWidth-1:HalfWidth];
    assign aLo = A[HalfWidth-1:0];
    assign bHi = B[WordWidth-1:HalfWidth];
    assign bLo = B[HalfWidth-1:0];

    // Unsigned 16x16, each fits a word exactly
    always_comb begin
        next.HiHi = word_t'(aHi) * word_t'(bHi);
        next.HiLo = word_t'(aHi) * word_t'(bLo);
        next.LoHi = word_t'(aLo) * word_t'(bHi);
        next.LoLo = word_t'(aLo) * word_t'(bLo);
    end

    // Products taken every cycle, whatever the op
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            Partials <= '0;
        end else if (!Hold) begin
            Partials <= next;
        end
    end

endmodule

`default_nettype wire

/* rtl/resultCombine.sv */
`default_nettype none
`timescale 1ns/1ps

module resultCombine (
    input  logic                  Clock,
    input  logic                  nReset,
    input  logic                  Hold,
    input  execPkg::aluStageOut_t AluIn,
    input  execPkg::partials_t    Partials,
    output logic                  ResultValid,
    output execPkg::execResult_t  Result
);
    import execPkg::*;

    dword_t      product;
    dword_t      accumulator;
    dword_t      accNext;
    word_t       selData;
    aluFlags_t   selFlags;
    execResult_t next;

    // Shift-add of the partial products ---------------
    assign product = (dword_t'(Partials.HiHi) << WordWidth)
                   + ((dword_t'(Partials.HiLo) + dword_t'(Partials.LoHi)) << HalfWidth)
                   + dword_t'(Partials.LoLo);

    // HI/LO accumulator, wraps at 64 bits
    always_comb begin
        accNext = accumulator;
        if (AluIn.Valid) begin
            case (AluIn.Func)
                FuncMultu: accNext = product;
                FuncMaddu: accNext = accumulator + product;
                default:   accNext = accumulator;
            endcase
        end
    end

    // Writeback value
    always_comb begin
        case (AluIn.Func)
            FuncMfhi: selData = accumulator[DwordWidth-1:WordWidth];
            FuncMflo: selData = accumulator[WordWidth-1:0];
            default:  selData = AluIn.Data;
        endcase
    end

    // Moves from HI/LO get flags like a logical op
    always_comb begin
        if (AluIn.Func == FuncMfhi || AluIn.Func == FuncMflo) begin
            selFlags = '{
                Carry:    1'b0,
                Zero:     (selData == '0),
                Overflow: 1'b0,
                Negative: selData[WordWidth-1]
            };
        end else begin
            selFlags = AluIn.Flags;
        end
    end

    assign next = '{
        RAddr:   AluIn.RAddr,
        WriteEn: AluIn.WriteEn,
        Data:    selData,
        Flags:   selFlags
    };

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            ResultValid <= 1'b0;
            Result      <= '0;
            accumulator <= '0;
        end else if (!Hold) begin
            ResultValid <= AluIn.Valid;
            Result      <= next;
            accumulator <= accNext;
        end
    end

    // Held cycles must not disturb HI/LO
    assert property (@(posedge Clock) disable iff (!nReset)
        Hold |=> $stable(accumulator));

endmodule

`default_nettype wire

/* rtl/executeCore.sv */
`default_nettype none
`timescale 1ns/1ps

module executeCore (
    input  logic                 Clock,
    input  logic                 nReset,
    input  logic                 Hold,
    input  logic                 IssueValid,
    input  execPkg::execOp_t     IssueOp,
    output logic                 ResultValid,
    output execPkg::execResult_t Result
);
    import execPkg::*;

    aluStageOut_t aluOut;
    partials_t    partials;

    // First execute stage -------------------------------
    aluStage u_alu (
        .Clock      (Clock),
        .nReset     (nReset),
        .Hold       (Hold),
        .IssueValid (IssueValid),
        .IssueOp    (IssueOp),
        .AluOut     (aluOut)
    );

    mulPartial u_mul (
        .Clock    (Clock),
        .nReset   (nReset),
        .Hold     (Hold),
        .A        (IssueOp.A),
        .B        (IssueOp.B),
        .Partials (partials)
    );

    // Second execute stage ------------------------------
    resultCombine u_combine (
        .Clock       (Clock),
        .nReset      (nReset),
        .Hold        (Hold),
        .AluIn       (aluOut),
        .Partials    (partials),
        .ResultValid (ResultValid),
        .Result      (Result)
    );

endmodule

`default_nettype wire

/* tb/clockGen.sv */
`default_nettype none
`timescale 1ns/1ps

module clockGen (
    output logic Clock,
    output logic nReset
);
    // 8 ns period
    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    initial begin
        nReset = 1'b0;
        repeat (16) @(posedge Clock);
        nReset <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/executeCoreTb.sv */
`default_nettype none
`timescale 1ns/1ps

module executeCoreTb;
    import execPkg::*;

    localparam int TimeoutCycles = 40;

    logic        Clock;
    logic        nReset;
    logic        Hold;
    logic        IssueValid;
    execOp_t     IssueOp;
    logic        ResultValid;
    execResult_t Result;

    word_t       seed = 32'h524e_d140;
    dword_t      accModel;
    int          cycle = 0;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          startErrors;
    logic        advanced = 1'b0;
    execResult_t expQ[$];
    execResult_t gotQ[$];
    int          kindQ[$];
    int          acceptQ[$];
    int          gotCycleQ[$];
    funcCode_t   aluFuncs[8] = '{FuncAdd, FuncSub, FuncAnd, FuncOr,
                                 FuncXor, FuncSlt, FuncSll, FuncSrl};

    clockGen u_clk (.Clock(Clock), .nReset(nReset));

    executeCore u_dut (
        .Clock       (Clock),
        .nReset      (nReset),
        .Hold        (Hold),
        .IssueValid  (IssueValid),
        .IssueOp     (IssueOp),
        .ResultValid (ResultValid),
        .Result      (Result)
    );

    // Monitors ---------------------------------------
    always @(posedge Clock) begin
        cycle = cycle + 1;
        advanced = !Hold;
        if (nReset && !Hold && IssueValid) begin
            // Issued on the edge before this one
            acceptQ.push_back(cycle - 1);
        end
    end

    // Only edges that advanced the pipe give a new result
    always @(negedge Clock) begin
        if (nReset && advanced && ResultValid) begin
            gotQ.push_back(Result);
            gotCycleQ.push_back(cycle);
        end
    end

    function automatic word_t nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t leadCount(input word_t v, input logic bitVal);
        word_t n;
        int    i;
        n = '0;
        i = WordWidth - 1;
        while (i >= 0 && v[i] == bitVal) begin
            n++;
            i--;
        end
        return n;
    endfunction

    // Reference model, called in issue order
    function automatic execResult_t modelOp(input execOp_t op);
        execResult_t        r;
        logic [WordWidth:0] wide;
        dword_t             prod;
        r = '0;
        r.RAddr = op.RAddr;
        r.WriteEn = op.RegWrite;
        prod = dword_t'(op.A) * dword_t'(op.B);
        case (op.Func)
            FuncAdd: begin
                wide = {1'b0, op.A} + {1'b0, op.B};
                r.Data = wide[WordWidth-1:0];
                r.Flags.Carry = wide[WordWidth];
                r.Flags.Overflow = (op.A[31] == op.B[31]) && (r.Data[31] != op.A[31]);
            end
            FuncSub: begin
                r.Data = op.A - op.B;
                r.Flags.Carry = (op.A >= op.B);
                r.Flags.Overflow = (op.A[31] != op.B[31]) && (r.Data[31] != op.A[31]);
            end
            FuncAnd:   r.Data = op.A & op.B;
            FuncOr:    r.Data = op.A | op.B;
            FuncXor:   r.Data = op.A ^ op.B;
            FuncSlt:   r.Data = ($signed(op.A) < $signed(op.B)) ? 32'd1 : 32'd0;
            FuncSll:   r.Data = op.B << op.Shamt;
            FuncSrl:   r.Data = op.B >> op.Shamt;
            FuncClz:   r.Data = leadCount(op.A, 1'b0);
            FuncClo:   r.Data = leadCount(op.A, 1'b1);
            FuncMovn:  r.Data = op.A;
            FuncMovz:  r.Data = op.A;
            FuncMultu: accModel = prod;
            FuncMaddu: accModel = accModel + prod;
            FuncMfhi:  r.Data = accModel[63:32];
            FuncMflo:  r.Data = accModel[31:0];
            default:   r.Data = '0;
        endcase
        if (op.Func == FuncMovn) r.WriteEn = op.RegWrite && (op.B != '0);
        if (op.Func == FuncMovz) r.WriteEn = op.RegWrite && (op.B == '0);
        if (op.Func == FuncMultu || op.Func == FuncMaddu) r.WriteEn = 1'b0;
        r.Flags.Zero = (r.Data == '0);
        r.Flags.Negative = r.Data[31];
        return r;
    endfunction

    function automatic execOp_t makeOp(input funcCode_t f, input word_t a, input word_t b,
                                       input shamt_t s, input logic w);
        execOp_t op;
        op.Func = f;
        op.A = a;
        op.B = b;
        op.Shamt = s;
        op.RAddr = regAddr_t'(nextRand() >> 20);
        op.RegWrite = w;
        return op;
    endfunction

    // Checks -----------------------------------------
    task automatic checkResult(input string name, input execResult_t exp,
                               input execResult_t act, input logic withData);
        if (withData && exp.Data !== act.Data) begin
            $display("[FAIL] %s Data: expected %h, actual %h", name, exp.Data, act.Data);
            errors++;
        end
        if (exp.RAddr !== act.RAddr) begin
            $display("[FAIL] %s RAddr: expected %0d, actual %0d", name, exp.RAddr, act.RAddr);
            errors++;
        end
        if (exp.WriteEn !== act.WriteEn) begin
            $display("[FAIL] %s WriteEn: expected %b, actual %b",
                     name, exp.WriteEn, act.WriteEn);
            errors++;
        end
    endtask

    task automatic checkFlags(input string name, input aluFlags_t exp, input aluFlags_t act);
        if (exp !== act) begin
            $display("[FAIL] %s Flags (CZVN): expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // kind 0 checks RAddr and WriteEn, 1 adds Data, 2 adds flags
    task automatic issue(input execOp_t op, input int kind);
        @(posedge Clock);
        IssueValid <= 1'b1;
        IssueOp    <= op;
        expQ.push_back(modelOp(op));
        kindQ.push_back(kind);
    endtask

    task automatic startTest();
        expQ.delete();
        gotQ.delete();
        kindQ.delete();
        acceptQ.delete();
        gotCycleQ.delete();
        startErrors = errors;
    endtask

    task automatic finishTest(input string name, input logic checkLatency);
        int waited;
        @(posedge Clock);
        IssueValid <= 1'b0;
        waited = 0;
        while (gotQ.size() < expQ.size() && waited < TimeoutCycles) begin
            @(posedge Clock);
            waited++;
        end
        repeat (3) @(posedge Clock);
        if (gotQ.size() < expQ.size()) begin
            $display("%s: timed out waiting for ResultValid, %0d of %0d results seen",
                     name, gotQ.size(), expQ.size());
            errors++;
        end else if (gotQ.size() > expQ.size()) begin
            $display("%s: %0d results seen but only %0d operations issued",
                     name, gotQ.size(), expQ.size());
            errors++;
        end else begin
            foreach (expQ[i]) begin
                checkResult($sformatf("%s #%0d", name, i), expQ[i], gotQ[i], kindQ[i] > 0);
                if (kindQ[i] > 1) checkFlags($sformatf("%s #%0d", name, i), expQ[i].Flags,
                                             gotQ[i].Flags);
                if (checkLatency && gotCycleQ[i] - acceptQ[i] != 2) begin
                    $display("%s #%0d: result came %0d cycles after issue instead of 2",
                             name, i, gotCycleQ[i] - acceptQ[i]);
                    errors++;
                end
            end
        end
        testsRun++;
        if (errors != startErrors) testsFailed++;
        $display("Test %-10s %0d ops, %0d errors", name, expQ.size(), errors - startErrors);
    endtask

    // Tests ------------------------------------------
    task automatic aluTest();
        word_t w;
        startTest();
        w = nextRand();
        issue(makeOp(FuncSub, w, w, '0, 1'b1), 2);
        for (int i = 0; i < 24; i++) begin
            issue(makeOp(aluFuncs[nextRand() % 8], nextRand(), nextRand(),
                         shamt_t'(nextRand() >> 9), 1'(nextRand() >> 16)), 2);
        end
        finishTest("alu", 1'b1);
    endtask

    task automatic countTest();
        word_t v;
        startTest();
        for (int i = 0; i < 8; i++) begin
            v = nextRand() >> (nextRand() % 32);
            if (i == 0) v = '0;
            if (i == 1) v = '1;
            issue(makeOp(FuncClz, v, nextRand(), '0, 1'b1), 2);
            issue(makeOp(FuncClo, ~v, nextRand(), '0, 1'b1), 2);
        end
        finishTest("count", 1'b1);
    endtask

    task automatic moveTest();
        word_t v;
        startTest();
        for (int i = 0; i < 8; i++) begin
            v = (i % 2) ? (nextRand() | 32'h1) : '0;
            issue(makeOp((i < 4) ? FuncMovn : FuncMovz, nextRand(), v, '0,
                         1'((i >> 1) % 2)), 2);
        end
        finishTest("move", 1'b1);
    endtask

    task automatic multiplyTest();
        startTest();
        for (int i = 0; i < 4; i++) begin
            issue(makeOp(FuncMultu, (i == 0) ? '1 : nextRand(), (i == 0) ? '1 : nextRand(),
                         '0, 1'b1), 0);
            issue(makeOp(FuncMfhi, nextRand(), nextRand(), '0, 1'b1), 1);
            issue(makeOp(FuncMflo, nextRand(), nextRand(), '0, 1'b1), 1);
        end
        finishTest("multiply", 1'b1);
    endtask

    task automatic accumulateTest();
        startTest();
        issue(makeOp(FuncMultu, nextRand(), nextRand(), '0, 1'b1), 0);
        // All-ones products force the 64-bit sum to wrap
        for (int i = 0; i < 6; i++) begin
            issue(makeOp(FuncMaddu, (i % 2) ? nextRand() : '1, '1, '0, 1'b1), 0);
        end
        issue(makeOp(FuncMfhi, '0, '0, '0, 1'b1), 1);
        issue(makeOp(FuncMflo, '0, '0, '0, 1'b1), 1);
        finishTest("accumulate", 1'b1);
    endtask

    task automatic holdTest();
        execResult_t snap;
        logic        snapValid;
        startTest();
        issue(makeOp(FuncMultu, nextRand(), nextRand(), '0, 1'b1), 0);
        issue(makeOp(FuncMaddu, nextRand(), nextRand(), '0, 1'b1), 0);
        issue(makeOp(FuncMaddu, nextRand(), nextRand(), '0, 1'b1), 0);
        // Ops offered during Hold must be dropped
        @(posedge Clock);
        Hold    <= 1'b1;
        IssueOp <= makeOp(FuncMaddu, '1, '1, '0, 1'b1);
        @(negedge Clock);
        snap = Result;
        snapValid = ResultValid;
        for (int i = 0; i < 5; i++) begin
            @(negedge Clock);
            if (Result !== snap || ResultValid !== snapValid) begin
                $display("[FAIL] hold Result: expected %h/%b, actual %h/%b",
                         snap, snapValid, Result, ResultValid);
                errors++;
            end
        end
        @(posedge Clock);
        Hold       <= 1'b0;
        IssueValid <= 1'b0;
        issue(makeOp(FuncMfhi, '0, '0, '0, 1'b1), 1);
        issue(makeOp(FuncMflo, '0, '0, '0, 1'b1), 1);
        finishTest("hold", 1'b0);
    endtask

    initial begin
        int waited;
        Hold       = 1'b0;
        IssueValid = 1'b0;
        IssueOp    = '0;
        accModel   = '0;
        waited     = 0;
        while (nReset !== 1'b1 && waited < 100) begin
            @(posedge Clock);
            waited++;
        end
        if (nReset === 1'b1) begin
            aluTest();
            countTest();
            moveTest();
            multiplyTest();
            accumulateTest();
            holdTest();
        end else begin
            $display("nReset was never released");
            errors++;
        end
        $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
                 testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/execPkg.sv
rtl/aluStage.sv
rtl/mulPartial.sv
rtl/resultCombine.sv
rtl/executeCore.sv
tb/clockGen.sv
tb/executeCoreTb.sv

/* Bender.yml */
package:
  name: execute_core

sources:
  - rtl/execPkg.sv
  - rtl/aluStage.sv
  - rtl/mulPartial.sv
  - rtl/resultCombine.sv
  - rtl/executeCore.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/executeCoreTb.sv
